// ==== Makefile ====
# Verilator build and run for the PE cluster testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tbPecCluster
RTL_TOP   ?= pecCluster
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tbPecCluster.sv ====
// Testbench for pecCluster with a credit-limited sender and result receiver.
// Fixed seed. Expected sums come from a direct per-column dot product model.
module tbPecCluster;
    timeunit 1ns;
    timeprecision 100ps;

    import pecDataPkg::*;
    import pecCtrlPkg::*;

    localparam int rowLen         = 8;
    localparam int actQueueDepth  = 4;
    localparam int resultCredits  = 2;
    localparam int rowBeats       = rowLen + kernelWidth - 1;
    localparam int resetCycles    = 5;
    // Rows sent over all tests
    localparam int numRows        = 8;
    localparam int watchdogCycles = 200 * numRows + resetCycles;
    localparam int weiTimeout     = 200 * numRows;

    typedef logic [rowLen-1:0][psumWidth-1:0] rowSumT;
    typedef actBlockT [rowBeats-1:0] rowBlocksT;

    // DUT ports
    logic    clk                = 1'b0;
    logic    rst_n              = 1'b0;
    logic    weiRdy             = 1'b0;
    weiRowT  wei                = '0;
    logic    weiGet;
    logic    actValid           = 1'b0;
    actBeatT act                = '0;
    logic    actCredit;
    logic    resultValid;
    resultT  result;
    logic    resultCreditReturn = 1'b0;

    // Bookkeeping
    int      seed        = 55;
    int      errCount    = 0;
    int      checkCount  = 0;
    int      sendCredit  = actQueueDepth;
    int      rxCredit    = resultCredits;
    int      stallCnt    = 0;
    int      loadsIssued = 0;
    int      weiGetCount = 0;
    logic    holdCredits = 1'b0;
    rowSumT  accRow      = '0;
    actBeatT sendQ [$];
    resultT  expQ [$];

    always #2 clk = ~clk;

    pecCluster #(
        .rowLen        (rowLen),
        .actQueueDepth (actQueueDepth),
        .resultCredits (resultCredits)
    ) i_pecCluster (
        .clk                (clk),
        .rst_n              (rst_n),
        .weiRdy             (weiRdy),
        .wei                (wei),
        .weiGet             (weiGet),
        .actValid           (actValid),
        .act                (act),
        .actCredit          (actCredit),
        .resultValid        (resultValid),
        .result             (result),
        .resultCreditReturn (resultCreditReturn)
    );

    // ==================================================
    // Checking helpers and reference model
    // ==================================================
    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            errCount++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expVal, actVal);
        end
    endtask

    task automatic noteFailure(input string what);
        errCount++;
        $display("t=%0t failure: %s", $time, what);
    endtask

    // Column c sums tap k over beat c + k, flagged channels only
    function automatic rowSumT refRow(input weiRowT w, input rowBlocksT blks,
                                      input rowSumT prev, input logic firstPass);
        rowSumT                      sums;
        int                          colSum;
        logic signed [dataWidth-1:0] a;
        logic signed [dataWidth-1:0] b;
        for (int c = 0; c < rowLen; c++) begin
            colSum = 0;
            for (int k = 0; k < kernelWidth; k++) begin
                for (int ch = 0; ch < blockDepth; ch++) begin
                    if (blks[c+k].flag[ch] && w[k].flag[ch]) begin
                        a = blks[c+k].val[ch];
                        b = w[k].val[ch];
                        colSum += int'(a) * int'(b);
                    end
                end
            end
            // Wraps at psumWidth like the hardware sum
            if (firstPass) begin
                sums[c] = psumWidth'(colSum);
            end else begin
                sums[c] = prev[c] + psumWidth'(colSum);
            end
        end
        return sums;
    endfunction

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic makeWeights(input logic dense, output weiRowT w);
        for (int k = 0; k < kernelWidth; k++) begin
            for (int ch = 0; ch < blockDepth; ch++) begin
                w[k].val[ch] = dataWidth'($random(seed));
            end
            w[k].flag = dense ? '1 : flagVecT'($random(seed));
        end
    endtask

    // Random values everywhere, zero skipping comes only from the flags
    task automatic queueRow(input weiRowT w, input logic denseAct,
                            input logic firstPass, input logic lastPass);
        rowBlocksT blks;
        actBeatT   beat;
        resultT    expRes;
        for (int b = 0; b < rowBeats; b++) begin
            for (int ch = 0; ch < blockDepth; ch++) begin
                blks[b].val[ch] = dataWidth'($random(seed));
            end
            blks[b].flag       = denseAct ? '1 : flagVecT'($random(seed));
            beat.blk           = blks[b];
            beat.tag.firstPass = firstPass;
            beat.tag.lastPass  = lastPass;
            sendQ.push_back(beat);
        end
        accRow = refRow(w, blks, accRow, firstPass);
        if (lastPass) begin
            for (int c = 0; c < rowLen; c++) begin
                expRes.col  = colIdxT'(c);
                expRes.psum = accRow[c];
                expQ.push_back(expRes);
            end
        end
    endtask

    // Holds weiRdy until the cluster answers with weiGet
    task automatic loadWeights(input weiRowT w);
        int   waited;
        logic got;
        waited = 0;
        got    = 1'b0;
        @(posedge clk);
        wei    <= w;
        weiRdy <= 1'b1;
        loadsIssued++;
        while (!got && waited < weiTimeout) begin
            @(posedge clk);
            got = weiGet;
            waited++;
        end
        weiRdy <= 1'b0;
        if (!got) begin
            noteFailure("weight load never acknowledged by weiGet");
        end
    endtask

    // ==================================================
    // Sender, receiver, monitor and checker processes
    // ==================================================
    // Sends only while holding an activation credit
    always @(posedge clk) begin : senderBlk
        if (rst_n) begin
            if (actCredit) begin
                sendCredit++;
            end
            if (sendCredit > actQueueDepth) begin
                noteFailure("sender credit count above actQueueDepth");
            end
            if (sendCredit > 0 && sendQ.size() > 0) begin
                act        <= sendQ.pop_front();
                actValid   <= 1'b1;
                sendCredit--;
            end else begin
                actValid <= 1'b0;
            end
        end
    end

    // Result receiver, returns credits randomly or in short windows when holding
    always @(posedge clk) begin : creditReturnBlk
        int owed;
        if (rst_n) begin
            if (resultValid) begin
                if (rxCredit == 0) begin
                    noteFailure("resultValid raised with no result credit left");
                end else begin
                    rxCredit--;
                end
            end
            if (resultCreditReturn) begin
                rxCredit++;
            end
            owed = resultCredits - rxCredit;
            stallCnt++;
            if (holdCredits) begin
                resultCreditReturn <= owed > 0 && (stallCnt % 48) >= 40;
            end else begin
                resultCreditReturn <= owed > 0 && ($random(seed) & 1) == 0;
            end
        end
    end

    always @(posedge clk) begin : weiGetMonBlk
        if (rst_n && weiGet) begin
            weiGetCount++;
        end
    end

    // Results must come out in column order, matching the model
    always @(posedge clk) begin : compareBlk
        resultT expRes;
        if (rst_n && resultValid) begin
            if (weiGetCount == 0) begin
                noteFailure("result before any weight load");
            end
            if (expQ.size() == 0) begin
                noteFailure("result with no expected value left");
            end else begin
                expRes = expQ.pop_front();
                checkVal("result.col", 32'(expRes.col), 32'(result.col));
                checkVal("result.psum", 32'(expRes.psum), 32'(result.psum));
            end
        end
    end

    initial begin : watchdogBlk
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, errors=%0d", watchdogCycles, errCount);
        $display("tests failed");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : mainBlk
        weiRowT w;
        repeat (resetCycles) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Idle outputs after reset
        checkVal("weiGet", 0, 32'(weiGet));
        checkVal("actCredit", 0, 32'(actCredit));
        checkVal("resultValid", 0, 32'(resultValid));

        // Dense single pass, beats waiting before the weights arrive
        makeWeights(1'b1, w);
        queueRow(w, 1'b1, 1'b1, 1'b1);
        repeat (20) @(posedge clk);
        checkVal("weiGet", 0, 32'(weiGet));
        loadWeights(w);

        // Random flags on both sides
        makeWeights(1'b0, w);
        loadWeights(w);
        queueRow(w, 1'b0, 1'b1, 1'b1);

        // First, middle and last pass, then a fresh group
        makeWeights(1'b0, w);
        loadWeights(w);
        queueRow(w, 1'b0, 1'b1, 1'b0);
        queueRow(w, 1'b0, 1'b0, 1'b0);
        queueRow(w, 1'b0, 1'b0, 1'b1);
        makeWeights(1'b0, w);
        loadWeights(w);
        queueRow(w, 1'b0, 1'b1, 1'b1);

        // Result credits withheld for long stretches
        holdCredits = 1'b1;
        makeWeights(1'b0, w);
        loadWeights(w);
        queueRow(w, 1'b0, 1'b1, 1'b0);
        queueRow(w, 1'b0, 1'b0, 1'b1);

        while (sendQ.size() != 0 || expQ.size() != 0) begin
            @(posedge clk);
        end
        // Catch any stray result
        repeat (20) @(posedge clk);
        checkVal("weiGet pulses", 32'(loadsIssued), 32'(weiGetCount));
        $display("checks=%0d errors=%0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/pecDataPkg.sv
verilog/pecCtrlPkg.sv
verilog/sparseMac.sv
verilog/convRow.sv
verilog/actCreditQueue.sv
verilog/psumBuffer.sv
verilog/pecSequencer.sv
verilog/pecCluster.sv
sim/tbPecCluster.sv

// ==== verilog/actCreditQueue.sv ====
// Activation FIFO with credit return. The sender starts with depth credits.
// One credit pulse follows each pop by one cycle.
module actCreditQueue #(
    parameter int depth = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inValid,
    input  pecCtrlPkg::actBeatT inBeat,
    output pecCtrlPkg::actBeatT head,
    output logic                headValid,
    input  logic                pop,
    output logic                credit
);
    import pecCtrlPkg::*;

    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);
    localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(depth - 1);

    actBeatT             mem [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                doPop;

    assign headValid = count != '0;
    assign head      = mem[rdPtr];
    assign doPop     = pop && headValid;

    always_ff @(posedge clk) begin
        if (inValid) begin
            mem[wrPtr] <= inBeat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // Circular pointers
            if (inValid) begin
                wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
            end
            if (inValid && !doPop) begin
                count <= count + 1'b1;
            end else if (!inValid && doPop) begin
                count <= count - 1'b1;
            end
            credit <= doPop;
        end
    end

    // A beat into a full queue means the sender spent a credit it never had
    assert property (@(posedge clk) disable iff (!rst_n) inValid |-> count != cntWidth'(depth))
        else $error("actCreditQueue overflow");

endmodule

// ==== verilog/convRow.sv ====
// One kernel row over an image row. Needs kernelWidth >= 2.
// A row is rowLen + kernelWidth - 1 beats, and the first kernelWidth - 1 emit nothing.
module convRow #(
    parameter int rowLen = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  pecCtrlPkg::actBeatT head,
    input  logic                headValid,
    output logic                pop,
    input  pecDataPkg::weiRowT  weights,
    input  logic                weiLoaded,
    output pecCtrlPkg::colPsumT colPsum,
    output logic                psumValid,
    input  logic                psumReady
);
    import pecDataPkg::*;
    import pecCtrlPkg::*;

    localparam int rowBeats = rowLen + kernelWidth - 1;
    localparam int cntWidth = $clog2(rowBeats);
    localparam logic [cntWidth-1:0] lastBeat = cntWidth'(rowBeats - 1);

    actBeatT                curBeat;
    logic                   macStart;
    logic                   macBusy;
    logic [kernelWidth-1:0] macDone;
    logic [kernelWidth-1:0] doneSeen;
    psumT                   macDot [kernelWidth];
    psumT                   chain [kernelWidth-1];
    logic                   allDone;
    logic [cntWidth-1:0]    beatCnt;

    // Take a beat only when idle, drained and loaded with weights
    assign pop     = weiLoaded && headValid && !macBusy && !psumValid;
    // Every tap finished in this or an earlier cycle
    assign allDone = macBusy && &(doneSeen | macDone);

    // Each dot output holds its sum until the next start
    for (genvar k = 0; k < kernelWidth; k++) begin : tapGen
        sparseMac i_mac (
            .clk     (clk),
            .rst_n   (rst_n),
            .start   (macStart),
            .act     (curBeat.blk),
            .wei     (weights[k].val),
            .weiFlag (weights[k].flag),
            .done    (macDone[k]),
            .dot     (macDot[k])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            macStart  <= 1'b0;
            macBusy   <= 1'b0;
            doneSeen  <= '0;
            psumValid <= 1'b0;
            beatCnt   <= '0;
        end else begin
            macStart <= pop;
            if (pop) begin
                macBusy  <= 1'b1;
                doneSeen <= '0;
            end else if (allDone) begin
                macBusy <= 1'b0;
            end else if (macBusy) begin
                doneSeen <= doneSeen | macDone;
            end
            if (psumReady) begin
                psumValid <= 1'b0;
            end
            if (allDone) begin
                // Columns start once the chain is full
                psumValid <= beatCnt >= cntWidth'(kernelWidth - 1);
                beatCnt   <= (beatCnt == lastBeat) ? '0 : beatCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            curBeat <= head;
        end
        if (allDone) begin
            // Transposed chain where entry m holds taps 0..m of column beatCnt - m
            chain[0] <= macDot[0];
            for (int m = 1; m < kernelWidth - 1; m++) begin
                chain[m] <= chain[m-1] + macDot[m];
            end
            colPsum.col     <= colIdxT'(beatCnt) - colIdxT'(kernelWidth - 1);
            colPsum.psum    <= chain[kernelWidth-2] + macDot[kernelWidth-1];
            colPsum.tag     <= curBeat.tag;
            colPsum.lastCol <= beatCnt == lastBeat;
        end
    end

endmodule

// ==== verilog/pecCluster.sv ====
// PE cluster top. Weights load by pulse handshake, activations and results use credits.
// The sender starts with actQueueDepth credits and the cluster with resultCredits.
module pecCluster #(
    parameter int rowLen        = 8,
    parameter int actQueueDepth = 4,
    parameter int resultCredits = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    // Weight port
    input  logic                weiRdy,
    input  pecDataPkg::weiRowT  wei,
    output logic                weiGet,
    // Activation port
    input  logic                actValid,
    input  pecCtrlPkg::actBeatT act,
    output logic                actCredit,
    // Result port
    output logic                resultValid,
    output pecCtrlPkg::resultT  result,
    input  logic                resultCreditReturn
);
    import pecDataPkg::*;
    import pecCtrlPkg::*;

    // ==================================================
    // Internal wiring
    // ==================================================
    actBeatT qHead;
    logic    qHeadValid;
    logic    qPop;
    weiRowT  weights;
    logic    weiLoaded;
    colPsumT colPsum;
    logic    psumValid;
    logic    psumReady;
    logic    rdEn;
    colIdxT  rdAddr;
    psumT    rdData;
    logic    wrEn;
    colIdxT  wrAddr;
    psumT    wrData;

    actCreditQueue #(.depth(actQueueDepth)) i_actQueue (
        .clk       (clk),
        .rst_n     (rst_n),
        .inValid   (actValid),
        .inBeat    (act),
        .head      (qHead),
        .headValid (qHeadValid),
        .pop       (qPop),
        .credit    (actCredit)
    );

    convRow #(.rowLen(rowLen)) i_convRow (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (qHead),
        .headValid (qHeadValid),
        .pop       (qPop),
        .weights   (weights),
        .weiLoaded (weiLoaded),
        .colPsum   (colPsum),
        .psumValid (psumValid),
        .psumReady (psumReady)
    );

    pecSequencer #(.resultCredits(resultCredits)) i_sequencer (
        .clk                (clk),
        .rst_n              (rst_n),
        .weiRdy             (weiRdy),
        .wei                (wei),
        .weiGet             (weiGet),
        .weights            (weights),
        .weiLoaded          (weiLoaded),
        .colPsum            (colPsum),
        .psumValid          (psumValid),
        .psumReady          (psumReady),
        .rdEn               (rdEn),
        .rdAddr             (rdAddr),
        .rdData             (rdData),
        .wrEn               (wrEn),
        .wrAddr             (wrAddr),
        .wrData             (wrData),
        .result             (result),
        .resultValid        (resultValid),
        .resultCreditReturn (resultCreditReturn)
    );

    psumBuffer #(.rowLen(rowLen)) i_psumBuffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

endmodule

// ==== verilog/pecCtrlPkg.sv ====
// Control and transport types of the PE cluster.
// Column indices are 8 bits, so rowLen is limited to 256.
package pecCtrlPkg;
    import pecDataPkg::*;

    localparam int colIdxWidth = 8;

    typedef logic [colIdxWidth-1:0] colIdxT;

    // Input-channel pass marks, constant across one row
    typedef struct packed {
        logic firstPass;
        logic lastPass;
    } passTagT;

    // One activation beat on the input side
    typedef struct packed {
        actBlockT blk;
        passTagT  tag;
    } actBeatT;

    // Finished column from the convolution row
    typedef struct packed {
        colIdxT  col;
        psumT    psum;
        passTagT tag;
        logic    lastCol;
    } colPsumT;

    typedef struct packed {
        colIdxT col;
        psumT   psum;
    } resultT;

    typedef enum logic {loadWei, run} seqStateT;

endpackage

// ==== verilog/pecDataPkg.sv ====
// Data formats of the PE cluster. Channel values are signed two's complement.
// Partial sums wrap modulo 2**psumWidth with no saturation.
package pecDataPkg;

    // ==================================================
    // Sizes
    // ==================================================
    // One channel value
    localparam int dataWidth   = 8;
    // Channels per activation or weight block
    localparam int blockDepth  = 16;
    // Taps in the kernel row
    localparam int kernelWidth = 3;
    // Product width plus accumulation headroom plus guard bits
    localparam int psumWidth   = 2 * dataWidth + $clog2(blockDepth) + 4;

    // ==================================================
    // Types
    // ==================================================
    typedef logic [blockDepth-1:0][dataWidth-1:0] chanVecT;
    typedef logic [blockDepth-1:0] flagVecT;

    // Values plus nonzero flags, same shape for activations and weights
    typedef struct packed {
        chanVecT val;
        flagVecT flag;
    } chanBlockT;

    typedef chanBlockT actBlockT;

    // Tap k sits at index k
    typedef chanBlockT [kernelWidth-1:0] weiRowT;

    typedef logic signed [psumWidth-1:0] psumT;

endpackage

// ==== verilog/pecSequencer.sv ====
// Weight load, partial-sum accumulation and credited result output.
// One column in flight at a time. Read in the accept cycle, add and write in the next.
module pecSequencer #(
    parameter int resultCredits = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                weiRdy,
    input  pecDataPkg::weiRowT  wei,
    output logic                weiGet,
    output pecDataPkg::weiRowT  weights,
    output logic                weiLoaded,
    input  pecCtrlPkg::colPsumT colPsum,
    input  logic                psumValid,
    output logic                psumReady,
    output logic                rdEn,
    output pecCtrlPkg::colIdxT  rdAddr,
    input  pecDataPkg::psumT    rdData,
    output logic                wrEn,
    output pecCtrlPkg::colIdxT  wrAddr,
    output pecDataPkg::psumT    wrData,
    output pecCtrlPkg::resultT  result,
    output logic                resultValid,
    input  logic                resultCreditReturn
);
    import pecDataPkg::*;
    import pecCtrlPkg::*;

    localparam int creditWidth = $clog2(resultCredits + 1);

    seqStateT               state;
    logic                   accept;
    logic                   pipeValid;
    colPsumT                pipeBeat;
    logic                   rowDone;
    psumT                   total;
    logic [creditWidth-1:0] creditCnt;

    // ==================================================
    // Weight handshake
    // ==================================================
    assign weiGet    = (state == loadWei) && weiRdy;
    // Last column of a last-pass row in the write stage
    assign rowDone   = pipeValid && pipeBeat.tag.lastPass && pipeBeat.lastCol;
    // Drops one cycle early so convRow cannot pop with stale weights
    assign weiLoaded = (state == run) && !rowDone;

    // ==================================================
    // Accumulation pipeline
    // ==================================================
    // Last-pass columns also need a result credit
    assign psumReady = (state == run) && !pipeValid &&
                       (!colPsum.tag.lastPass || creditCnt != '0);
    assign accept    = psumValid && psumReady;
    assign rdEn      = accept;
    assign rdAddr    = colPsum.col;

    always_comb begin
        // First pass ignores whatever the buffer holds
        total = pipeBeat.psum;
        if (!pipeBeat.tag.firstPass) begin
            total = rdData + pipeBeat.psum;
        end
        result.col  = pipeBeat.col;
        result.psum = total;
    end

    assign wrEn        = pipeValid;
    assign wrAddr      = pipeBeat.col;
    assign wrData      = total;
    assign resultValid = pipeValid && pipeBeat.tag.lastPass;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= loadWei;
            pipeValid <= 1'b0;
            creditCnt <= creditWidth'(resultCredits);
        end else begin
            case (state)
                loadWei: if (weiGet) state <= run;
                run:     if (rowDone) state <= loadWei;
                default: state <= loadWei;
            endcase
            pipeValid <= accept;
            if (resultCreditReturn && !resultValid) begin
                creditCnt <= creditCnt + 1'b1;
            end else if (!resultCreditReturn && resultValid) begin
                creditCnt <= creditCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (weiGet) begin
            weights <= wei;
        end
        if (accept) begin
            pipeBeat <= colPsum;
        end
    end

    // Receiver returned more credits than it was given
    assert property (@(posedge clk) disable iff (!rst_n)
        creditCnt <= creditWidth'(resultCredits))
        else $error("result credit overflow");

endmodule

// ==== verilog/psumBuffer.sv ====
// Partial-sum store, one word per output column, registered read.
// Addresses must stay below rowLen.
module psumBuffer #(
    parameter int rowLen = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rdEn,
    input  pecCtrlPkg::colIdxT rdAddr,
    output pecDataPkg::psumT   rdData,
    input  logic               wrEn,
    input  pecCtrlPkg::colIdxT wrAddr,
    input  pecDataPkg::psumT   wrData
);
    import pecDataPkg::*;

    localparam int addrWidth = (rowLen > 1) ? $clog2(rowLen) : 1;

    psumT mem [rowLen];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr[addrWidth-1:0]] <= wrData;
        end
    end

    // Read data one cycle after rdEn, held until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdData <= '0;
        end else if (rdEn) begin
            rdData <= mem[rdAddr[addrWidth-1:0]];
        end
    end

endmodule

// ==== verilog/sparseMac.sv ====
// Zero-skipping dot product of one block. act and wei must stay stable until done.
// Takes one cycle per channel with both flags set, at least one cycle.
module sparseMac (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  pecDataPkg::actBlockT act,
    input  pecDataPkg::chanVecT  wei,
    input  pecDataPkg::flagVecT  weiFlag,
    output logic                 done,
    output pecDataPkg::psumT     dot
);
    import pecDataPkg::*;

    localparam int idxWidth = $clog2(blockDepth);

    logic                          busy;
    flagVecT                       mask;
    psumT                          acc;
    flagVecT                       curMask;
    flagVecT                       remMask;
    logic [idxWidth-1:0]           idx;
    logic signed [2*dataWidth-1:0] prod;
    psumT                          sum;

    // Channels still to visit, fresh from both flag sets on start
    assign curMask = busy ? mask : (act.flag & weiFlag);
    // Drop the lowest set bit
    assign remMask = curMask & (curMask - 1'b1);

    // Lowest set channel and its product
    always_comb begin
        idx = '0;
        for (int i = blockDepth - 1; i >= 0; i--) begin
            if (curMask[i]) begin
                idx = idxWidth'(i);
            end
        end
        prod = '0;
        if (|curMask) begin
            prod = $signed(act.val[idx]) * $signed(wei[idx]);
        end
        sum = prod;
        if (busy) begin
            sum = acc + prod;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start || busy) begin
                // Finish in the step that consumes the last set bit
                busy <= |remMask;
                done <= ~|remMask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            mask <= remMask;
            acc  <= sum;
            if (remMask == '0) begin
                dot <= sum;
            end
        end
    end

    // Row control must wait for the previous block
    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("sparseMac started while busy");

endmodule
